// File: logic/i2c_pkg.sv
`default_nettype none

package i2c_pkg;

    typedef enum logic [4:0] {
        idle,
        start,
        addr_high,          // 11110 a9 a8 0
        ack_addr_high,
        addr_low,           // a7 down to a0
        ack_addr_low,
        restart,            // Repeated START ahead of the read header
        addr_read,          // 11110 a9 a8 1
        ack_addr_read,
        write_data,
        ack_write,
        read_data,
        nack_read,          // Master answers the read byte with NACK
        stop
    } seq_state_t;

    typedef enum logic [2:0] {
        sel_hdr_write,
        sel_hdr_read,
        sel_addr_low,
        sel_wdata,
        sel_clear           // Empty byte before a read
    } byte_sel_t;

    typedef struct packed {
        logic       rw;     // 1 selects a read
        logic [9:0] addr;
        logic [7:0] wdata;
    } i2c_cmd_t;

    typedef struct packed {
        logic       done;
        logic       ack_err;    // Slave answered NACK
        logic [7:0] rdata;
    } i2c_result_t;

    localparam logic [4:0] HEADER_PREFIX = 5'b11110;
    localparam int QUARTER_TICKS = 4;                   // Clocks per quarter of an SCL bit
    localparam int QUARTER_W     = $clog2(QUARTER_TICKS);

endpackage

`default_nettype wire

// File: logic/apb_regs_pkg.sv
`default_nettype none

package apb_regs_pkg;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [4:0]  paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    localparam logic [4:0] REG_CTRL   = 5'h00;
    localparam logic [4:0] REG_ADDR   = 5'h04;
    localparam logic [4:0] REG_TXDATA = 5'h08;
    localparam logic [4:0] REG_RXDATA = 5'h0C;     // Read only
    localparam logic [4:0] REG_STATUS = 5'h10;

    // CTRL fields
    localparam int CTRL_START_BIT = 0;             // Write one to launch
    localparam int CTRL_RW_BIT    = 1;

    // STATUS fields where a written one clears done or ack_err
    localparam int STATUS_BUSY_BIT = 0;
    localparam int STATUS_DONE_BIT = 1;
    localparam int STATUS_ERR_BIT  = 2;

endpackage

`default_nettype wire

// File: logic/apb_regs.sv
`default_nettype none

module apb_regs (
    input  logic                   clk,
    input  logic                   rst,
    input  apb_regs_pkg::apb_req_t req,
    output logic [31:0]            prdata,
    output logic                   pready,
    output logic                   pslverr,
    input  logic                   busy,
    input  logic                   result_valid,
    input  i2c_pkg::i2c_result_t   result,
    output i2c_pkg::i2c_cmd_t      cmd,
    output logic                   go
);
    import apb_regs_pkg::*;
    import i2c_pkg::*;

    logic        access;        // Access phase of any transfer
    logic        wr_en;
    logic        mapped;
    logic        start_req;
    logic        busy_view;     // Busy from go until done reads one
    i2c_result_t status_q;      // Last result with sticky done and ack_err

    assign access    = req.psel && req.penable;
    assign busy_view = busy || go || result_valid;
    assign start_req = access && req.pwrite && (req.paddr == REG_CTRL)
                       && req.pwdata[CTRL_START_BIT];

    always_comb begin
        case (req.paddr)
            REG_CTRL, REG_ADDR, REG_TXDATA, REG_RXDATA, REG_STATUS: mapped = 1'b1;
            default: mapped = 1'b0;
        endcase
    end

    assign pready  = 1'b1;                                  // No wait states
    assign pslverr = access && (!mapped || (start_req && busy_view));
    assign wr_en   = access && req.pwrite && !pslverr;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cmd      <= '0;
            go       <= 1'b0;
            status_q <= '0;
        end else begin
            go <= wr_en && start_req;
            if (wr_en) begin
                case (req.paddr)
                    REG_CTRL:   cmd.rw    <= req.pwdata[CTRL_RW_BIT];
                    REG_ADDR:   cmd.addr  <= req.pwdata[9:0];
                    REG_TXDATA: cmd.wdata <= req.pwdata[7:0];
                    REG_STATUS: begin
                        if (req.pwdata[STATUS_DONE_BIT]) begin
                            status_q.done <= 1'b0;
                        end
                        if (req.pwdata[STATUS_ERR_BIT]) begin
                            status_q.ack_err <= 1'b0;
                        end
                    end
                    default: ;                              // RXDATA ignores writes
                endcase
            end
            if (result_valid) begin
                status_q <= result;
            end
        end
    end

    always_comb begin
        prdata = 32'h0;
        if (access && !req.pwrite) begin
            case (req.paddr)
                REG_CTRL:   prdata[CTRL_RW_BIT] = cmd.rw;   // Start reads back as zero
                REG_ADDR:   prdata[9:0] = cmd.addr;
                REG_TXDATA: prdata[7:0] = cmd.wdata;
                REG_RXDATA: prdata[7:0] = status_q.rdata;
                REG_STATUS: begin
                    prdata[STATUS_BUSY_BIT] = busy_view;
                    prdata[STATUS_DONE_BIT] = status_q.done;
                    prdata[STATUS_ERR_BIT]  = status_q.ack_err;
                end
                default: prdata = 32'h0;
            endcase
        end
    end

    // A new transaction is never launched over a running one
    assert property (@(posedge clk) disable iff (rst) $rose(go) |-> !busy)
        else $error("go raised while the sequencer was busy");

endmodule

`default_nettype wire

// File: logic/i2c_bit_timer.sv
`default_nettype none

module i2c_bit_timer (
    input  logic clk,
    input  logic rst,
    input  logic run,
    output logic tick
);
    import i2c_pkg::*;

    logic [QUARTER_W-1:0] count;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            count <= '0;
            tick  <= 1'b0;
        end else if (!run) begin
            count <= '0;                    // First quarter of a transfer is whole
            tick  <= 1'b0;
        end else if (count == QUARTER_W'(QUARTER_TICKS - 1)) begin
            count <= '0;
            tick  <= 1'b1;
        end else begin
            count <= count + 1'b1;
            tick  <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: logic/i2c_sequencer.sv
`default_nettype none

module i2c_sequencer (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 go,
    input  i2c_pkg::i2c_cmd_t    cmd,
    input  logic                 tick,
    input  logic                 sda_in,
    input  logic                 tx_bit,
    input  logic [7:0]           rx_byte,
    output logic                 run,
    output logic                 busy,
    output logic                 scl,
    output logic                 sda_pull,
    output logic                 load,
    output logic                 shift,
    output logic                 sample,
    output i2c_pkg::byte_sel_t   byte_sel,
    output logic                 result_valid,
    output i2c_pkg::i2c_result_t result
);
    import i2c_pkg::*;

    seq_state_t state;
    seq_state_t next_state;
    logic [1:0] quarter;        // Quarter of the current SCL bit
    logic [2:0] bit_cnt;        // Bit position inside a byte state
    logic       sda_rise;       // SDA taken at the SCL rising edge
    logic       ack_err;
    logic       end_bit;        // Last tick of a bit
    logic       rise_tick;      // Tick that raises SCL
    logic       in_ack;
    logic       in_tx_byte;
    logic       scl_data;       // SCL shape of an ordinary bit

    assign end_bit    = tick && (quarter == 2'd3);
    assign rise_tick  = tick && (quarter == 2'd0);
    assign in_ack     = state inside {ack_addr_high, ack_addr_low, ack_addr_read, ack_write};
    assign in_tx_byte = state inside {addr_high, addr_low, addr_read, write_data};
    assign scl_data   = (quarter == 2'd1) || (quarter == 2'd2);

    assign busy   = (state != idle);
    assign run    = busy;
    assign shift  = end_bit && in_tx_byte;
    assign sample = rise_tick && (state == read_data);

    always_comb begin
        next_state = state;
        load       = 1'b0;
        byte_sel   = sel_clear;
        if (state == idle) begin
            if (go) begin
                next_state = start;
            end
        end else if (end_bit) begin
            if (in_ack && sda_rise) begin
                next_state = stop;              // NACK ends the transfer at once
            end else begin
                case (state)
                    start: begin
                        next_state = addr_high;
                        load       = 1'b1;
                        byte_sel   = sel_hdr_write;
                    end
                    addr_high: if (bit_cnt == 3'd7) next_state = ack_addr_high;
                    ack_addr_high: begin
                        next_state = addr_low;
                        load       = 1'b1;
                        byte_sel   = sel_addr_low;
                    end
                    addr_low: if (bit_cnt == 3'd7) next_state = ack_addr_low;
                    ack_addr_low: begin
                        if (cmd.rw) begin
                            next_state = restart;
                        end else begin
                            next_state = write_data;
                            load       = 1'b1;
                            byte_sel   = sel_wdata;
                        end
                    end
                    restart: begin
                        next_state = addr_read;
                        load       = 1'b1;
                        byte_sel   = sel_hdr_read;
                    end
                    addr_read: if (bit_cnt == 3'd7) next_state = ack_addr_read;
                    ack_addr_read: begin
                        next_state = read_data;
                        load       = 1'b1;
                        byte_sel   = sel_clear;
                    end
                    write_data: if (bit_cnt == 3'd7) next_state = ack_write;
                    ack_write:  next_state = stop;
                    read_data:  if (bit_cnt == 3'd7) next_state = nack_read;
                    nack_read:  next_state = stop;
                    default:    next_state = idle;  // Leaving stop
                endcase
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state        <= idle;
            quarter      <= 2'd0;
            bit_cnt      <= 3'd0;
            sda_rise     <= 1'b0;
            ack_err      <= 1'b0;
            result_valid <= 1'b0;
        end else begin
            state        <= next_state;
            result_valid <= (state == stop) && end_bit;
            if (tick) begin
                quarter <= quarter + 2'd1;
            end
            if (rise_tick) begin
                sda_rise <= sda_in;
            end
            if (end_bit) begin
                bit_cnt <= (next_state == state) ? bit_cnt + 3'd1 : 3'd0;
            end
            if (state == idle && go) begin
                ack_err <= 1'b0;
            end else if (end_bit && in_ack && sda_rise) begin
                ack_err <= 1'b1;
            end
        end
    end

    // Pin levels per state and quarter
    always_comb begin
        scl      = scl_data;
        sda_pull = 1'b0;
        case (state)
            idle: scl = 1'b1;
            start: begin
                scl      = (quarter != 2'd3);
                sda_pull = (quarter != 2'd0);       // SDA falls with SCL high
            end
            restart:  sda_pull = (quarter >= 2'd2);
            stop: begin
                scl      = (quarter != 2'd0);
                sda_pull = (quarter < 2'd2);        // SDA rises with SCL high
            end
            addr_high, addr_low, addr_read, write_data: sda_pull = !tx_bit;
            default:  sda_pull = 1'b0;              // Slave owns SDA here
        endcase
    end

    always_comb begin
        result.done    = result_valid;
        result.ack_err = ack_err;
        result.rdata   = rx_byte;
    end

    assert property (@(posedge clk) disable iff (rst)
        ($changed(sda_pull) && scl && $past(scl)) |-> (state inside {start, restart, stop}))
        else $error("SDA moved under a high SCL outside START, repeated START or STOP");

    // The result follows a STOP that left both lines released
    assert property (@(posedge clk) disable iff (rst)
        result_valid |-> (($past(state) == stop) && $past(scl) && !$past(sda_pull)))
        else $error("result_valid without a completed STOP on the bus");

endmodule

`default_nettype wire

// File: logic/i2c_shifter.sv
`default_nettype none

module i2c_shifter (
    input  logic               clk,
    input  logic               rst,
    input  i2c_pkg::i2c_cmd_t  cmd,
    input  logic               load,
    input  logic               shift,
    input  logic               sample,
    input  i2c_pkg::byte_sel_t byte_sel,
    input  logic               sda_in,
    output logic               tx_bit,
    output logic [7:0]         rx_byte
);
    import i2c_pkg::*;

    logic [7:0] shreg;
    logic [7:0] load_byte;

    // Byte picked by the sequencer for the next phase
    always_comb begin
        case (byte_sel)
            sel_hdr_write: load_byte = {HEADER_PREFIX, cmd.addr[9:8], 1'b0};
            sel_hdr_read:  load_byte = {HEADER_PREFIX, cmd.addr[9:8], 1'b1};
            sel_addr_low:  load_byte = cmd.addr[7:0];
            sel_wdata:     load_byte = cmd.wdata;
            default:       load_byte = 8'h00;       // Cleared before a read
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            shreg <= 8'h00;
        end else if (load) begin
            shreg <= load_byte;
        end else if (sample) begin
            shreg <= {shreg[6:0], sda_in};          // Read bits enter at the LSB
        end else if (shift) begin
            shreg <= {shreg[6:0], 1'b0};
        end
    end

    assign tx_bit  = shreg[7];                      // MSB first on the wire
    assign rx_byte = shreg;

endmodule

`default_nettype wire

// File: logic/i2c_master_top.sv
`default_nettype none

module i2c_master_top (
    input  logic                   clk,
    input  logic                   rst,
    input  apb_regs_pkg::apb_req_t req,
    output logic [31:0]            prdata,
    output logic                   pready,
    output logic                   pslverr,
    output logic                   scl,
    inout  wire                    sda
);
    import i2c_pkg::*;

    i2c_cmd_t    cmd;
    i2c_result_t result;
    byte_sel_t   byte_sel;
    logic        go;
    logic        busy;
    logic        run;
    logic        tick;
    logic        sda_pull;
    logic        sda_in;
    logic        load;
    logic        shift;
    logic        sample;
    logic        tx_bit;
    logic        result_valid;
    logic [7:0]  rx_byte;

    // Open drain with the pull-up outside the chip
    assign sda    = sda_pull ? 1'b0 : 1'bz;
    assign sda_in = sda;

    apb_regs u_regs (
        .clk          (clk),
        .rst          (rst),
        .req          (req),
        .prdata       (prdata),
        .pready       (pready),
        .pslverr      (pslverr),
        .busy         (busy),
        .result_valid (result_valid),
        .result       (result),
        .cmd          (cmd),
        .go           (go)
    );

    i2c_bit_timer u_timer (
        .clk  (clk),
        .rst  (rst),
        .run  (run),
        .tick (tick)
    );

    i2c_sequencer u_seq (
        .clk          (clk),
        .rst          (rst),
        .go           (go),
        .cmd          (cmd),
        .tick         (tick),
        .sda_in       (sda_in),
        .tx_bit       (tx_bit),
        .rx_byte      (rx_byte),
        .run          (run),
        .busy         (busy),
        .scl          (scl),
        .sda_pull     (sda_pull),
        .load         (load),
        .shift        (shift),
        .sample       (sample),
        .byte_sel     (byte_sel),
        .result_valid (result_valid),
        .result       (result)
    );

    i2c_shifter u_shifter (
        .clk      (clk),
        .rst      (rst),
        .cmd      (cmd),
        .load     (load),
        .shift    (shift),
        .sample   (sample),
        .byte_sel (byte_sel),
        .sda_in   (sda_in),
        .tx_bit   (tx_bit),
        .rx_byte  (rx_byte)
    );

endmodule

`default_nettype wire

// File: verif/i2c_master_checker.sv
`default_nettype none

module i2c_master_checker (
    input  logic                   clk,
    input  logic                   rst,
    input  apb_regs_pkg::apb_req_t req,
    input  logic [31:0]            prdata,
    input  logic                   pslverr,
    input  logic                   scl,
    input  wire                    sda
);
    timeunit 1ns;
    timeprecision 100ps;

    string       test_name = "";
    string       trace = "";            // Bus events seen during the current test
    int          test_errs = 0;
    int          pass_count = 0;
    int          fail_count = 0;
    bit          exp_pending = 0;
    string       exp_label = "";
    logic [31:0] exp_data = '0;
    logic        exp_err = 1'b0;
    bit          in_txn = 0;
    int          bit_cnt = 0;
    logic [8:0]  frame = '0;            // Eight data bits and the acknowledge bit

    task automatic begin_test(input string name);
        test_name = name;
        test_errs = 0;
        trace = "";
    endtask

    task automatic check_value(input string label, input logic [31:0] exp,
                               input logic [31:0] act);
        if (act !== exp) begin
            $display("[FAIL] %s %s: expected %h, actual %h", test_name, label, exp, act);
            test_errs++;
        end
    endtask

    task automatic expect_access(input string label, input logic [31:0] data,
                                 input logic err);
        exp_label = label;
        exp_data = data;
        exp_err = err;
        exp_pending = 1;
    endtask

    task automatic end_test(input string exp_trace);
        if (exp_pending) begin
            $display("Test %s: an expected APB access never took place", test_name);
            exp_pending = 0;
            test_errs++;
        end
        if (trace != exp_trace) begin
            $display("[FAIL] %s bus: expected \"%s\", actual \"%s\"", test_name, exp_trace, trace);
            test_errs++;
        end
        if (test_errs == 0) begin
            pass_count++;
            $display("Test %s passed", test_name);
        end else begin
            fail_count++;
            $display("Test %s failed with %0d mismatches", test_name, test_errs);
        end
    endtask

    task automatic report();
        $display("Tests run %0d, passed %0d, failed %0d", pass_count + fail_count,
                 pass_count, fail_count);
    endtask

    // APB outputs are steady in the middle of the access phase
    always @(negedge clk) begin
        if (exp_pending && req.psel && req.penable) begin
            exp_pending = 0;
            check_value({exp_label, " pslverr"}, 32'(exp_err), 32'(pslverr));
            if (!req.pwrite) begin
                check_value(exp_label, exp_data, prdata);
            end
        end
    end

    always @(negedge sda) begin
        if (!rst && scl === 1'b1) begin
            if (in_txn) begin
                trace = {trace, " Sr"};         // Repeated START
            end else begin
                trace = {trace, " S"};
            end
            in_txn = 1;
            bit_cnt = 0;
        end
    end

    always @(posedge sda) begin
        if (!rst && scl === 1'b1 && in_txn) begin
            trace = {trace, " P"};
            in_txn = 0;
        end
    end

    always @(posedge scl) begin
        if (in_txn) begin
            frame = {frame[7:0], sda};
            bit_cnt++;
            if (bit_cnt == 9) begin
                trace = {trace, $sformatf(" %02h%s", frame[8:1], frame[0] ? "N" : "A")};
                bit_cnt = 0;
            end
        end
    end

endmodule

`default_nettype wire

// File: verif/tb_i2c_master.sv
`default_nettype none

module tb_i2c_master;
    timeunit 1ns;
    timeprecision 100ps;
    import apb_regs_pkg::*;

    localparam logic [9:0] SLAVE_ADDR = 10'h2A5;
    localparam int CLK_NS     = 20;
    localparam int TXN_CLOCKS = 40 * 16;       // Longest transaction in system clocks

    logic        clk;
    logic        rst;
    apb_req_t    req;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic        scl;
    wire         sda;
    int          limit_ns = 0;
    logic [31:0] rng = 32'hacca_a075;

    string       names[$];
    int          kinds[$];                      // 0 write, 1 read, 2 write with a rejected start
    logic [9:0]  addrs[$];
    logic [7:0]  wbytes[$];
    logic [7:0]  rbytes[$];
    int          errs[$];

    // Slave model state
    logic        slave_pull = 1'b0;
    logic [7:0]  slave_rbyte = 8'h00;
    logic [7:0]  slave_wcap = 8'h00;
    logic [7:0]  s_byte = 8'h00;
    int          s_cnt = 0;
    int          s_phase = 0;                   // 0 header, 1 low address, 2 data in, 3 data out
    logic        s_addr_ok = 1'b0;
    logic        s_tx_next = 1'b0;

    pullup (sda);
    assign sda = slave_pull ? 1'b0 : 1'bz;

    i2c_master_top dut (
        .clk     (clk),
        .rst     (rst),
        .req     (req),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .scl     (scl),
        .sda     (sda)
    );

    i2c_master_checker chk (
        .clk     (clk),
        .rst     (rst),
        .req     (req),
        .prdata  (prdata),
        .pslverr (pslverr),
        .scl     (scl),
        .sda     (sda)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    always @(negedge sda) begin
        if (!rst && scl === 1'b1) begin
            s_cnt = 0;
            s_phase = 0;
        end
    end

    always @(posedge sda) begin
        if (!rst && scl === 1'b1) begin            // STOP forgets the address match
            s_cnt = 0;
            s_phase = 0;
            s_addr_ok = 1'b0;
            s_tx_next = 1'b0;
        end
    end

    always @(posedge scl) begin
        s_byte = {s_byte[6:0], sda};
        s_cnt++;
    end

    // Slave changes SDA only while SCL is low
    always @(negedge scl) begin
        if (s_cnt == 9) begin
            s_cnt = 0;
            slave_pull = 1'b0;
            if (s_tx_next) begin
                s_tx_next = 1'b0;
                s_phase = 3;
                slave_pull = !slave_rbyte[7];
            end
        end else if (s_phase == 3 && s_cnt < 8) begin
            slave_pull = !slave_rbyte[7 - s_cnt];
        end else if (s_cnt == 8) begin
            slave_pull = 1'b0;
            case (s_phase)
                0: if (s_byte[7:1] == {5'b11110, SLAVE_ADDR[9:8]}) begin
                    if (!s_byte[0]) begin
                        slave_pull = 1'b1;
                        s_phase = 1;
                    end else if (s_addr_ok) begin
                        slave_pull = 1'b1;
                        s_tx_next = 1'b1;
                    end
                end
                1: if (s_byte == SLAVE_ADDR[7:0]) begin
                    slave_pull = 1'b1;
                    s_addr_ok = 1'b1;
                    s_phase = 2;
                end
                2: begin
                    slave_wcap = s_byte;
                    slave_pull = 1'b1;
                end
                default: ;                          // Master answers the read byte
            endcase
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // Expected bus events from the 10-bit addressing rules and the slave address
    function automatic string bus_trace(input int kind, input logic [9:0] addr,
                                        input logic [7:0] wbyte, input logic [7:0] rbyte);
        string      t;
        logic [7:0] hdr;
        hdr = {5'b11110, addr[9:8], 1'b0};
        if (addr[9:8] != SLAVE_ADDR[9:8]) begin
            return $sformatf(" S %02hN P", hdr);
        end
        t = $sformatf(" S %02hA", hdr);
        if (addr != SLAVE_ADDR) begin
            return {t, $sformatf(" %02hN P", addr[7:0])};
        end
        t = {t, $sformatf(" %02hA", addr[7:0])};
        if (kind == 1) begin
            return {t, $sformatf(" Sr %02hA %02hN P", hdr | 8'h01, rbyte)};
        end
        return {t, $sformatf(" %02hA P", wbyte)};
    endfunction

    task automatic apb_access(input logic write, input logic [4:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata);
        @(posedge clk);
        #2;
        req.psel = 1'b1;                            // Setup phase
        req.penable = 1'b0;
        req.pwrite = write;
        req.paddr = addr;
        req.pwdata = wdata;
        @(posedge clk);
        #2;
        req.penable = 1'b1;
        #6;
        rdata = prdata;
        @(posedge clk);
        #2;
        req = '0;
    endtask

    initial begin
        wait (limit_ns > 0);
        #(limit_ns);
        $display("Timeout: the run did not finish within %0d ns", limit_ns);
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        int                fd;
        logic [8*128-1:0]  line_r;
        logic [8*32-1:0]   name_r;
        int                kind;
        logic [9:0]        addr;
        logic [7:0]        wb;
        logic [7:0]        rb;
        int                err;
        logic [31:0]       rd;
        req = '0;
        rst = 1'b1;
        fd = $fopen("verif/i2c_stimulus.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the stimulus file verif/i2c_stimulus.txt");
            $display("=== FAIL ===");
            $finish;
        end else begin
            while ($fgets(line_r, fd) != 0) begin
                if ($sscanf(line_r, "%s %d %h %h %h %d",
                            name_r, kind, addr, wb, rb, err) == 6) begin
                    names.push_back($sformatf("%0s", name_r));
                    kinds.push_back(kind);
                    addrs.push_back(addr);
                    wbytes.push_back(wb);
                    rbytes.push_back(rb);
                    errs.push_back(err);
                end
            end
            $fclose(fd);
            limit_ns = (names.size() + 2) * (TXN_CLOCKS + 160) * CLK_NS;
            repeat (3) @(posedge clk);
            #2;
            rst = 1'b0;

            chk.begin_test("reset_state");
            chk.check_value("scl", 32'd1, 32'(scl));
            chk.check_value("sda", 32'd1, 32'(sda));
            chk.check_value("pready", 32'd1, 32'(pready));
            chk.expect_access("STATUS", 32'h0, 1'b0);
            apb_access(1'b0, REG_STATUS, 32'h0, rd);
            chk.expect_access("unmapped", 32'h0, 1'b1);
            apb_access(1'b0, 5'h14, 32'h0, rd);
            chk.end_test("");

            foreach (names[i]) begin
                chk.begin_test(names[i]);
                slave_rbyte = rbytes[i];
                slave_wcap = 8'h00;
                apb_access(1'b1, REG_ADDR, 32'(addrs[i]), rd);
                apb_access(1'b1, REG_TXDATA, 32'(wbytes[i]), rd);
                chk.expect_access("CTRL", 32'h0, 1'b0);
                apb_access(1'b1, REG_CTRL, {30'h0, kinds[i] == 1, 1'b1}, rd);
                if (kinds[i] == 2) begin
                    chk.expect_access("start while busy", 32'h0, 1'b1);
                    apb_access(1'b1, REG_CTRL, 32'h1, rd);
                end
                rd = '0;
                while (!rd[1]) begin                // Wait for done
                    apb_access(1'b0, REG_STATUS, 32'h0, rd);
                    if (!rd[1]) begin
                        chk.check_value("busy", 32'd1, 32'(rd[0]));
                    end
                end
                chk.expect_access("STATUS", {29'h0, errs[i] != 0, 2'b10}, 1'b0);
                apb_access(1'b0, REG_STATUS, 32'h0, rd);
                if (kinds[i] == 1 && errs[i] == 0) begin
                    chk.expect_access("RXDATA", 32'(rbytes[i]), 1'b0);
                    apb_access(1'b0, REG_RXDATA, 32'h0, rd);
                end else if (errs[i] == 0) begin
                    chk.check_value("slave byte", 32'(wbytes[i]), 32'(slave_wcap));
                end
                apb_access(1'b1, REG_STATUS, 32'h6, rd);
                chk.expect_access("STATUS cleared", 32'h0, 1'b0);
                apb_access(1'b0, REG_STATUS, 32'h0, rd);
                chk.end_test(bus_trace(kinds[i], addrs[i], wbytes[i], rbytes[i]));
                rng = xorshift(rng);
                repeat (rng % 16) @(posedge clk);   // Random idle gap
            end

            chk.report();
            if (chk.fail_count == 0 && chk.pass_count == names.size() + 1) begin
                $display("=== PASS ===");
            end else begin
                $display("=== FAIL ===");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: i2c_master_top.f
logic/i2c_pkg.sv
logic/apb_regs_pkg.sv
logic/apb_regs.sv
logic/i2c_bit_timer.sv
logic/i2c_sequencer.sv
logic/i2c_shifter.sv
logic/i2c_master_top.sv
verif/i2c_master_checker.sv
verif/tb_i2c_master.sv

// File: verif/i2c_stimulus.txt
# name kind(0 write, 1 read, 2 write with a start written while busy) addr wbyte rbyte err
# addr, wbyte and rbyte in hex; err is the expected ack_err flag in STATUS
write_a5 0 2a5 3c 00 0
write_zero 0 2a5 00 00 0
write_ones 0 2a5 ff 00 0
read_5a 1 2a5 00 5a 0
read_81 1 2a5 00 81 0
read_ones 1 2a5 00 ff 0
nack_write_hdr 0 1a5 55 00 1
nack_read_hdr 1 0a5 00 77 1
nack_low_addr 0 2a4 12 00 1
nack_read_low 1 2b5 00 66 1
busy_start 2 2a5 c3 00 0
read_after_nack 1 2a5 00 e7 0
write_after_read 0 2a5 96 00 0
read_zero 1 2a5 00 00 0
write_alt 0 2a5 a5 00 0
busy_start_2 2 2a5 18 00 0
